// File: hdl/decodeStage.sv
module decodeStage
(
	input logic clk,
	input logic rstN,
	input mipsPkg::ifIdT ifId,
	input mipsPkg::wbT wb, // register file write port
	output mipsPkg::idExT idEx,
	output logic stall
);

	mipsPkg::wordT regs [32]; // register file
	logic [5:0] opcode;
	logic [5:0] funct;
	mipsPkg::regAddrT rs;
	mipsPkg::regAddrT rt;
	mipsPkg::regAddrT dest;
	mipsPkg::wordT imm;
	mipsPkg::wordT opA;
	mipsPkg::wordT opB;
	mipsPkg::ctrlT ctrl;
	mipsPkg::aluOpT aluOp;
	logic useRt; // rt is a source operand

	// r0 reads zero, writeback bypasses the array
	function automatic mipsPkg::wordT readReg(mipsPkg::regAddrT idx);
		if (idx == '0)
			return '0;
		if (wb.valid && wb.rd == idx)
			return wb.data;
		return regs[idx];
	endfunction

	assign opcode = ifId.instr[mipsPkg::OPC_LSB +: 6];
	assign funct = ifId.instr[mipsPkg::FN_LSB +: 6];
	assign rs = ifId.instr[mipsPkg::RS_LSB +: 5];
	assign rt = ifId.instr[mipsPkg::RT_LSB +: 5];
	assign dest = (opcode == mipsPkg::OP_RTYPE) ? ifId.instr[mipsPkg::RD_LSB +: 5] : rt;
	assign imm = {{(mipsPkg::XLEN - mipsPkg::IMM_W){ifId.instr[mipsPkg::IMM_W-1]}},
		ifId.instr[mipsPkg::IMM_W-1:0]};

	always_comb
	begin
		ctrl = '0;
		aluOp = mipsPkg::ALU_ADD; // address calc and addi
		useRt = 1'b0;
		case (opcode)
			mipsPkg::OP_RTYPE:
			begin
				ctrl.regWrite = 1'b1;
				useRt = 1'b1;
				case (funct)
					mipsPkg::FN_ADD: aluOp = mipsPkg::ALU_ADD;
					mipsPkg::FN_SUB: aluOp = mipsPkg::ALU_SUB;
					mipsPkg::FN_AND: aluOp = mipsPkg::ALU_AND;
					mipsPkg::FN_OR: aluOp = mipsPkg::ALU_OR;
					mipsPkg::FN_SLT: aluOp = mipsPkg::ALU_SLT;
					default: ctrl.regWrite = 1'b0; // unknown funct, also the all-zero nop
				endcase
			end
			mipsPkg::OP_ADDI:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			mipsPkg::OP_LW:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			mipsPkg::OP_SW:
			begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				useRt = 1'b1; // store data
			end
			default: ctrl = '0;
		endcase
		if (!ifId.valid)
			ctrl = '0;
		if (dest == '0)
			ctrl.regWrite = 1'b0; // r0 never written
	end

	always_comb
	begin
		opA = readReg(rs);
		opB = readReg(rt);
	end

	// lw directly ahead feeding this instruction
	assign stall = ifId.valid && idEx.ctrl.memRead && idEx.ctrl.regWrite
		&& (idEx.rd == rs || (useRt && idEx.rd == rt));

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wb.valid && wb.rd != '0)
			regs[wb.rd] <= wb.data;
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			idEx <= '0;
		else
		begin
			idEx.ctrl <= stall ? '0 : ctrl; // bubble while ifId holds
			idEx.aluOp <= aluOp;
			idEx.rs <= rs;
			idEx.rt <= rt;
			idEx.rd <= dest;
			idEx.opA <= opA;
			idEx.opB <= opB;
			idEx.imm <= imm;
		end
	end

endmodule

// File: hdl/executeStage.sv
module executeStage
(
	input logic clk,
	input logic rstN,
	input mipsPkg::idExT idEx,
	input mipsPkg::wbT memWb, // older result for forwarding
	output mipsPkg::exMemT exMem
);

	mipsPkg::wordT fwdA;
	mipsPkg::wordT fwdB; // forwarded rt, doubles as store data
	mipsPkg::wordT aluB;
	mipsPkg::wordT aluRes;

	// newest producer wins
	function automatic mipsPkg::wordT forward(
		input mipsPkg::regAddrT idx,
		input mipsPkg::wordT decoded,
		input mipsPkg::exMemT em,
		input mipsPkg::wbT mw
	);
		if (em.ctrl.regWrite && em.rd == idx)
			return em.aluRes; // never a lw, load-use stall sees to that
		if (mw.valid && mw.rd == idx)
			return mw.data;
		return decoded;
	endfunction

	assign fwdA = forward(idEx.rs, idEx.opA, exMem, memWb);
	assign fwdB = forward(idEx.rt, idEx.opB, exMem, memWb);
	assign aluB = idEx.ctrl.aluSrc ? idEx.imm : fwdB;

	always_comb
	begin
		case (idEx.aluOp)
			mipsPkg::ALU_ADD: aluRes = fwdA + aluB;
			mipsPkg::ALU_SUB: aluRes = fwdA - aluB;
			mipsPkg::ALU_AND: aluRes = fwdA & aluB;
			mipsPkg::ALU_OR: aluRes = fwdA | aluB;
			mipsPkg::ALU_SLT:
			begin
				// signed compare
				aluRes = mipsPkg::wordT'($signed(fwdA) < $signed(aluB));
			end
			default: aluRes = fwdA + aluB;
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			exMem <= '0;
		else
		begin
			exMem.ctrl <= idEx.ctrl;
			exMem.rd <= idEx.rd;
			exMem.aluRes <= aluRes; // also the memory address
			exMem.storeData <= fwdB;
		end
	end

endmodule

// File: hdl/fetchStage.sv
module fetchStage #(
	parameter int IMEM_DEPTH = 64
)
(
	input logic clk,
	input logic rstN,
	input logic run,
	input logic stall, // load-use hold from decode
	input logic imemWe,
	input mipsPkg::wordT imemAddr, // word index, not byte address
	input mipsPkg::wordT imemData,
	output mipsPkg::ifIdT ifId
);

	localparam int IAW = $clog2(IMEM_DEPTH);

	mipsPkg::wordT imem [IMEM_DEPTH]; // instruction memory
	mipsPkg::wordT pc; // byte address
	logic [IAW-1:0] fetchIdx;

	assign fetchIdx = pc[2 +: IAW]; // drop byte offset

	// program load port, only while halted
	always_ff @(posedge clk)
	begin
		if (imemWe && !run)
			imem[imemAddr[IAW-1:0]] <= imemData;
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			pc <= '0;
			ifId <= '0;
		end
		else if (!run)
		begin
			pc <= '0; // restart at word 0
			ifId <= '0; // bubble
		end
		else if (!stall)
		begin
			pc <= pc + 4;
			ifId.valid <= 1'b1;
			ifId.instr <= imem[fetchIdx];
		end
		// stall holds pc and ifId
	end

endmodule

// File: hdl/memoryStage.sv
module memoryStage #(
	parameter int DMEM_DEPTH = 64
)
(
	input logic clk,
	input logic rstN,
	input mipsPkg::exMemT exMem,
	output mipsPkg::wbT memWb,
	output mipsPkg::wbT wb,
	output mipsPkg::storeT store
);

	localparam int DAW = $clog2(DMEM_DEPTH);

	mipsPkg::wordT dmem [DMEM_DEPTH]; // data memory
	logic [DAW-1:0] memIdx;
	mipsPkg::wordT rdData;

	assign memIdx = exMem.aluRes[2 +: DAW]; // word index
	assign rdData = dmem[memIdx]; // async read

	always_ff @(posedge clk)
	begin
		if (exMem.ctrl.memWrite)
			dmem[memIdx] <= exMem.storeData;
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			memWb <= '0;
			store <= '0;
		end
		else
		begin
			memWb.valid <= exMem.ctrl.regWrite;
			memWb.rd <= exMem.rd;
			memWb.data <= exMem.ctrl.memToReg ? rdData : exMem.aluRes;
			store.valid <= exMem.ctrl.memWrite; // strobe, same edge as the write
			store.addr <= exMem.aluRes;
			store.data <= exMem.storeData;
		end
	end

	assign wb = memWb; // writeback bus

endmodule

// File: hdl/mipsCore.sv
module mipsCore #(
	parameter int IMEM_DEPTH = 64,
	parameter int DMEM_DEPTH = 64
)
(
	input logic clk,
	input logic rstN,
	input logic run, // low to load the program
	input logic imemWe,
	input mipsPkg::wordT imemAddr,
	input mipsPkg::wordT imemData,
	output mipsPkg::wbT wb,
	output mipsPkg::storeT store
);

	mipsPkg::ifIdT ifId;
	mipsPkg::idExT idEx;
	mipsPkg::exMemT exMem;
	mipsPkg::wbT memWb; // forwarding source
	logic stall;

	fetchStage #(
		.IMEM_DEPTH(IMEM_DEPTH)
	) fetch (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.stall(stall),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.ifId(ifId)
	);

	decodeStage decode (
		.clk(clk),
		.rstN(rstN),
		.ifId(ifId),
		.wb(wb), // regfile write port
		.idEx(idEx),
		.stall(stall)
	);

	executeStage execute (
		.clk(clk),
		.rstN(rstN),
		.idEx(idEx),
		.memWb(memWb),
		.exMem(exMem)
	);

	memoryStage #(
		.DMEM_DEPTH(DMEM_DEPTH)
	) memory (
		.clk(clk),
		.rstN(rstN),
		.exMem(exMem),
		.memWb(memWb),
		.wb(wb),
		.store(store)
	);

endmodule

// File: hdl/mipsPkg.sv
package mipsPkg;

	localparam int XLEN = 32; // data and instruction width

	typedef logic [4:0] regAddrT;
	typedef logic [XLEN-1:0] wordT;

	// instruction field positions
	localparam int OPC_LSB = 26;
	localparam int RS_LSB = 21;
	localparam int RT_LSB = 16;
	localparam int RD_LSB = 11;
	localparam int FN_LSB = 0;
	localparam int IMM_W = 16; // immediate width before sign extension

	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI = 6'h08;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;

	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} aluOpT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg; // writeback takes load data
		logic aluSrc; // immediate as second alu input
	} ctrlT;

	typedef struct packed {
		logic valid;
		wordT instr;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		aluOpT aluOp;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd; // destination, rt or rd field
		wordT opA;
		wordT opB;
		wordT imm; // sign extended
	} idExT;

	typedef struct packed {
		ctrlT ctrl;
		regAddrT rd;
		wordT aluRes;
		wordT storeData;
	} exMemT;

	// memory/writeback payload and the writeback bus
	typedef struct packed {
		logic valid;
		regAddrT rd;
		wordT data;
	} wbT;

	typedef struct packed {
		logic valid;
		wordT addr; // byte address of the stored word
		wordT data;
	} storeT;

endpackage

// File: mipsCore.f
hdl/mipsPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/mipsCore.sv
verif/mipsCoreProperties.sv
verif/mipsCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
	--top-module mipsCoreTb \
	-Mdir obj_dir \
	-f mipsCore.f

./obj_dir/VmipsCoreTb | tee sim.log

if grep -q "TB FAILED" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

echo "simulation finished, see sim.log"

// File: verif/mipsCoreProperties.sv
module mipsCoreProperties
(
	input logic clk,
	input logic rstN,
	input mipsPkg::wbT wb,
	input mipsPkg::storeT store
);

	timeunit 1ns;
	timeprecision 100ps;

	// decode squashes every write to r0
	noWbToR0: assert property (@(posedge clk) disable iff (!rstN)
		wb.valid |-> wb.rd != '0)
		else $error("writeback names register 0");

	// both buses idle while held in reset
	quietInReset: assert property (@(posedge clk)
		!rstN |-> !wb.valid && !store.valid)
		else $error("writeback or store bus active during reset");

	wbDataKnown: assert property (@(posedge clk) disable iff (!rstN)
		wb.valid |-> !$isunknown(wb.data))
		else $error("writeback data unknown while valid");

endmodule

// File: verif/mipsCoreTb.sv
module mipsCoreTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int IMEM_DEPTH = 64;
	localparam int DMEM_DEPTH = 64;
	localparam int TIMEOUT = 200; // cycles allowed per program
	localparam mipsPkg::wordT MARKER = 32'h0000_00fc; // last store of each program

	logic clk;
	logic rstN;
	logic run;
	logic imemWe;
	mipsPkg::wordT imemAddr;
	mipsPkg::wordT imemData;
	mipsPkg::wbT wb;
	mipsPkg::storeT store;

	mipsPkg::wordT prog[$]; // program of the current test
	mipsPkg::wbT expWb[$];
	mipsPkg::storeT expStore[$];
	mipsPkg::wbT gotWb[$]; // as observed
	mipsPkg::storeT gotStore[$];
	logic [8*24-1:0] testName;
	int fd;
	int testErrors;
	int testsRun;
	int testsFailed;

	mipsCore #(
		.IMEM_DEPTH(IMEM_DEPTH),
		.DMEM_DEPTH(DMEM_DEPTH)
	) dut (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.wb(wb),
		.store(store)
	);

	bind mipsCore mipsCoreProperties props (
		.clk(clk),
		.rstN(rstN),
		.wb(wb),
		.store(store)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// one test block, from T up to E
	task automatic readTest(output bit found);
		string line;
		byte tag;
		mipsPkg::wordT a;
		mipsPkg::wordT b;
		mipsPkg::wbT w;
		mipsPkg::storeT s;
		bit done;
		found = 1'b0;
		done = 1'b0;
		testName = '0;
		prog.delete();
		expWb.delete();
		expStore.delete();
		while (!done && $fgets(line, fd) > 0)
		begin
			void'($sscanf(line, "%c %h %h", tag, a, b));
			case (tag)
				"T":
				begin
					void'($sscanf(line, "%c %s", tag, testName));
					found = 1'b1;
				end
				"P": prog.push_back(a);
				"W":
				begin
					w.valid = 1'b1;
					w.rd = a[4:0];
					w.data = b;
					expWb.push_back(w);
				end
				"S":
				begin
					s.valid = 1'b1;
					s.addr = a;
					s.data = b;
					expStore.push_back(s);
				end
				"E": done = 1'b1;
				default: ; // comment or blank line
			endcase
		end
	endtask

	task automatic resetCore();
		@(posedge clk);
		rstN <= 1'b0;
		run <= 1'b0;
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
	endtask

	// whole imem written, words past the program are funct-0 no-ops tagged with their index
	task automatic loadProgram();
		for (int i = 0; i < IMEM_DEPTH; i++)
		begin
			@(posedge clk);
			imemWe <= 1'b1;
			imemAddr <= mipsPkg::wordT'(i);
			if (i < prog.size())
				imemData <= prog[i];
			else
				imemData <= {mipsPkg::OP_RTYPE, 20'(i), 6'h00};
		end
		@(posedge clk);
		imemWe <= 1'b0;
	endtask

	task automatic collectEvents(output bit timedOut);
		bit sawMarker;
		int cycles;
		gotWb.delete();
		gotStore.delete();
		sawMarker = 1'b0;
		cycles = 0;
		while (!sawMarker && cycles < TIMEOUT)
		begin
			@(negedge clk); // buses settled mid cycle
			cycles++;
			if (wb.valid)
				gotWb.push_back(wb);
			if (store.valid)
			begin
				gotStore.push_back(store);
				sawMarker = (store.addr == MARKER);
			end
		end
		timedOut = !sawMarker;
	endtask

	task automatic checkWb(input int idx, input mipsPkg::wbT got, input mipsPkg::wbT exp);
		if (got !== exp)
		begin
			testErrors++;
			$display("CHECK FAILED wb[%0d] rd %h data %h, expected rd %h data %h",
				idx, got.rd, got.data, exp.rd, exp.data);
		end
	endtask

	task automatic checkStore(input int idx, input mipsPkg::storeT got,
		input mipsPkg::storeT exp);
		if (got !== exp)
		begin
			testErrors++;
			$display("CHECK FAILED store[%0d] addr %h data %h, expected addr %h data %h",
				idx, got.addr, got.data, exp.addr, exp.data);
		end
	endtask

	task automatic compareEvents();
		for (int i = 0; i < gotWb.size() && i < expWb.size(); i++)
			checkWb(i, gotWb[i], expWb[i]);
		for (int i = 0; i < gotStore.size() && i < expStore.size(); i++)
			checkStore(i, gotStore[i], expStore[i]);
		if (gotWb.size() != expWb.size())
		begin
			testErrors++;
			$display("%0s: saw %0d writebacks where %0d were expected",
				testName, gotWb.size(), expWb.size());
		end
		if (gotStore.size() != expStore.size())
		begin
			testErrors++;
			$display("%0s: saw %0d stores where %0d were expected",
				testName, gotStore.size(), expStore.size());
		end
	endtask

	task automatic runTest();
		bit timedOut;
		testErrors = 0;
		resetCore();
		loadProgram();
		@(posedge clk);
		run <= 1'b1;
		collectEvents(timedOut);
		@(posedge clk);
		run <= 1'b0; // halt, next reset flushes
		if (timedOut)
		begin
			testErrors++;
			$display("%0s: marker store did not arrive within %0d cycles", testName, TIMEOUT);
		end
		compareEvents();
		testsRun++;
		if (testErrors == 0)
			$display("test %0s ok", testName);
		else
		begin
			testsFailed++;
			$display("test %0s failed with %0d errors", testName, testErrors);
		end
	endtask

	initial
	begin
		bit found;
		rstN = 1'b0;
		run = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		testsRun = 0;
		testsFailed = 0;
		fd = $fopen("verif/mipsCoreTests.txt", "r");
		if (fd == 0)
		begin
			testsFailed++;
			$display("could not open verif/mipsCoreTests.txt");
		end
		else
		begin
			readTest(found);
			while (found)
			begin
				runTest();
				readTest(found);
			end
			$fclose(fd);
			if (testsRun == 0)
				$display("no tests found in verif/mipsCoreTests.txt");
		end
		$display("tests run %0d, tests failed %0d", testsRun, testsFailed);
		if (testsFailed == 0 && testsRun > 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: verif/mipsCoreTests.txt
# T test name | P instruction word | W dest register, value | S byte address, data | E end
# every program ends with sw r0, 0xfc(r0), the marker store that stops the run
T aluIndependent
P 20010007 # addi r1, r0, 7
P 2002fffd # addi r2, r0, -3
P 00000000 # nop
P 00000000 # nop
P 00000000 # nop
P 00221820 # add r3, r1, r2
P 00222022 # sub r4, r1, r2
P 00222824 # and r5, r1, r2
P 00223025 # or r6, r1, r2
P 0041382a # slt r7, r2, r1
P 0022402a # slt r8, r1, r2
P 20290100 # addi r9, r1, 0x100
P ac0000fc # marker
W 01 00000007
W 02 fffffffd
W 03 00000004
W 04 0000000a
W 05 00000005
W 06 ffffffff
W 07 00000001
W 08 00000000
W 09 00000107
S 000000fc 00000000
E
T forwardChain
P 20010005 # addi r1, r0, 5
P 20220003 # addi r2, r1, 3    rs from exMem
P 00221820 # add r3, r1, r2    memWb and exMem
P 00612022 # sub r4, r3, r1    exMem and regfile bypass
P 00832820 # add r5, r4, r3
P 20a50001 # addi r5, r5, 1
P ac0000fc # marker
W 01 00000005
W 02 00000008
W 03 0000000d
W 04 00000008
W 05 00000015
W 05 00000016
S 000000fc 00000000
E
T loadUse
P 20010040 # addi r1, r0, 0x40
P 20021234 # addi r2, r0, 0x1234
P ac220000 # sw r2, 0(r1)
P 8c230000 # lw r3, 0(r1)
P 00632020 # add r4, r3, r3    stalls on rs and rt
P 8c250000 # lw r5, 0(r1)
P 20a60001 # addi r6, r5, 1    stalls on rs
P ac0000fc # marker
W 01 00000040
W 02 00001234
W 03 00001234
W 04 00002468
W 05 00001234
W 06 00001235
S 00000040 00001234
S 000000fc 00000000
E
T storeForward
P 20010010 # addi r1, r0, 0x10
P 20020055 # addi r2, r0, 0x55
P 00421820 # add r3, r2, r2
P ac230004 # sw r3, 4(r1)      data from exMem
P 8c240004 # lw r4, 4(r1)
P ac240008 # sw r4, 8(r1)      load then store, stall
P ac0000fc # marker
W 01 00000010
W 02 00000055
W 03 000000aa
W 04 000000aa
S 00000014 000000aa
S 00000018 000000aa
S 000000fc 00000000
E
T regZero
P 20000077 # addi r0, r0, 0x77  dropped
P 20010005 # addi r1, r0, 5
P 00210020 # add r0, r1, r1    dropped
P 00011020 # add r2, r0, r1
P 00001825 # or r3, r0, r0
P ac000020 # sw r0, 0x20(r0)
P ac0000fc # marker
W 01 00000005
W 02 00000005
W 03 00000000
S 00000020 00000000
S 000000fc 00000000
E
